// ==== hdl/ntm_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// NTM controller package
// Lane count, fixed point types and FSM encodings shared by the
// feeder, the neuron lanes, the logistic drain and the top level
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package ntm_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////////////

  // Neurons computed in parallel
  localparam int NUM_LANES = 4;

  // Q8.8 data word
  localparam int WORD_W = 16;

  // Q16.16 accumulator
  localparam int ACC_W = 32;

  // Job length in operand beats
  localparam int LEN_W = 8;

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic signed [WORD_W-1:0] word_t;
  typedef logic signed [ACC_W-1:0]  acc_t;
  typedef logic [LEN_W-1:0]         len_t;

  // Lane 0 sits in the low bits
  typedef logic [NUM_LANES*WORD_W-1:0] word_row_t;
  typedef logic [NUM_LANES*ACC_W-1:0]  acc_row_t;

  // Feeder job sequencing
  typedef enum logic [1:0] {
    FEED_IDLE,
    FEED_RUN,
    FEED_WAIT
  } feeder_state_t;

  // Drain output sequencing
  typedef enum logic {
    DRAIN_IDLE,
    DRAIN_SEND
  } drain_state_t;

  ////////////////////////////////////////////////////////////////////////////
  // Constants
  ////////////////////////////////////////////////////////////////////////////

  // Saturation limits of the accumulator
  localparam acc_t ACC_MAX = {1'b0, {(ACC_W-1){1'b1}}};
  localparam acc_t ACC_MIN = {1'b1, {(ACC_W-1){1'b0}}};

  // 1.0 in Q8.8
  localparam word_t H_ONE = 16'sd256;

endpackage

`default_nettype wire

// ==== hdl/ntm_operand_feeder.sv ====
////////////////////////////////////////////////////////////////////////////
// NTM operand feeder
// Accepts a job start with bias row and length, then takes operand
// beats (element plus one weight per lane) over valid/ready and
// broadcasts them to all neuron lanes as registered step pulses.
// Holds off new jobs until the drain reports completion.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module ntm_operand_feeder
  import ntm_pkg::*;
(
  input  wire       CLK,
  input  wire       RST,
  // Job start
  input  wire       START,
  output logic      READY,
  input  len_t      LENGTH_IN,
  input  word_row_t B_IN,
  // Operand stream
  input  wire       X_VALID,
  output logic      X_READY,
  input  word_t     X_ELEM,
  input  word_row_t X_WEIGHTS,
  // End of job from the drain
  input  wire       drain_done,
  // Lane control
  output logic      lane_load,
  output word_row_t bias_row,
  output logic      lane_step,
  output logic      lane_last,
  output word_t     step_elem,
  output word_row_t step_weights
);

  feeder_state_t state;

  // Job length and beats taken so far
  len_t len_q;
  len_t beat_cnt;
  len_t beat_cnt_next;

  logic beat_xfer;

  assign beat_xfer     = X_VALID && X_READY;
  assign beat_cnt_next = beat_cnt + len_t'(1);

  ////////////////////////////////////////////////////////////////////////////
  // Job FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= FEED_IDLE;
      READY     <= 1'b1;
      X_READY   <= 1'b0;
      lane_load <= 1'b0;
      lane_step <= 1'b0;
      lane_last <= 1'b0;
      len_q     <= '0;
      beat_cnt  <= '0;
    end else begin
      // Pulses default low
      lane_load <= 1'b0;
      lane_step <= 1'b0;
      lane_last <= 1'b0;

      case (state)
        FEED_IDLE: begin
          if (START) begin
            // Latch job, preload lanes, open the operand stream
            len_q     <= LENGTH_IN;
            beat_cnt  <= '0;
            lane_load <= 1'b1;
            READY     <= 1'b0;
            X_READY   <= 1'b1;
            state     <= FEED_RUN;
          end
        end

        FEED_RUN: begin
          // X_VALID low just pauses here
          if (beat_xfer) begin
            lane_step <= 1'b1;
            beat_cnt  <= beat_cnt_next;
            if (beat_cnt_next == len_q) begin
              // Final beat, close the stream
              lane_last <= 1'b1;
              X_READY   <= 1'b0;
              state     <= FEED_WAIT;
            end
          end
        end

        FEED_WAIT: begin
          // Single job in flight, wait for last h word
          if (drain_done) begin
            READY <= 1'b1;
            state <= FEED_IDLE;
          end
        end

        default: begin
          state   <= FEED_IDLE;
          READY   <= 1'b1;
          X_READY <= 1'b0;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Payload registers
  ////////////////////////////////////////////////////////////////////////////

  // Bias follows the start, step data follows each beat
  always_ff @(posedge CLK) begin
    if (state == FEED_IDLE && START) begin
      bias_row <= B_IN;
    end
    if (beat_xfer) begin
      step_elem    <= X_ELEM;
      step_weights <= X_WEIGHTS;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/ntm_neuron_lane.sv ====
////////////////////////////////////////////////////////////////////////////
// NTM neuron lane
// One Q16.16 accumulator: loaded with the bias, then summing
// element times weight on every step with saturation
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module ntm_neuron_lane
  import ntm_pkg::*;
(
  input  wire   CLK,
  input  wire   RST,
  input  wire   lane_load,
  input  word_t bias,
  input  wire   lane_step,
  input  wire   lane_last,
  input  word_t step_elem,
  input  word_t weight,
  output acc_t  acc,
  output logic  lane_done
);

  // Q8.8 times Q8.8 lands directly in Q16.16
  acc_t prod;

  // One guard bit to catch overflow
  logic signed [ACC_W:0] sum_wide;
  acc_t                  sum_sat;

  // Bias widened into Q16.16
  acc_t bias_ext;

  assign prod     = acc_t'(step_elem) * acc_t'(weight);
  assign sum_wide = {acc[ACC_W-1], acc} + {prod[ACC_W-1], prod};
  assign bias_ext = acc_t'(bias) <<< 8;

  // Guard and sign bit differ on overflow
  always_comb begin
    if (sum_wide[ACC_W] != sum_wide[ACC_W-1]) begin
      // Guard bit gives the true sign
      sum_sat = sum_wide[ACC_W] ? ACC_MIN : ACC_MAX;
    end else begin
      sum_sat = sum_wide[ACC_W-1:0];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Accumulator
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      acc       <= '0;
      lane_done <= 1'b0;
    end else begin
      if (lane_load) begin
        acc <= bias_ext;
      end else if (lane_step) begin
        acc <= sum_sat;
      end
      // Sum valid together with this flag
      lane_done <= lane_step && lane_last;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/ntm_logistic_drain.sv ====
////////////////////////////////////////////////////////////////////////////
// NTM logistic drain
// Captures the lane sums when the lanes finish, maps each through a
// hard sigmoid and streams the h words out in lane order over
// valid/ready, flagging the last lane
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module ntm_logistic_drain
  import ntm_pkg::*;
(
  input  wire      CLK,
  input  wire      RST,
  // From the lanes
  input  wire      lane_done,
  input  acc_row_t acc_row,
  // Result stream
  output logic     H_VALID,
  input  wire      H_READY,
  output word_t    H_OUT,
  output logic     H_LAST,
  // Back to the feeder
  output logic     drain_done
);

  drain_state_t state;

  // Lane currently presented on H_OUT
  logic [$clog2(NUM_LANES)-1:0] lane_idx;

  // Sums held for the whole send phase
  acc_row_t acc_row_q;

  acc_t  acc_sel;
  acc_t  h_lin;
  logic  h_xfer;
  logic  last_lane;

  assign H_VALID   = (state == DRAIN_SEND);
  assign h_xfer    = H_VALID && H_READY;
  assign last_lane = (lane_idx == NUM_LANES - 1);
  assign H_LAST    = last_lane;

  ////////////////////////////////////////////////////////////////////////////
  // Hard sigmoid
  ////////////////////////////////////////////////////////////////////////////

  // 0.25*a + 0.5: shift by 16-8+2 to reach Q8.8 quarter, 0.5 is 128
  assign acc_sel = acc_row_q[lane_idx*ACC_W +: ACC_W];
  assign h_lin   = (acc_sel >>> 10) + acc_t'(128);

  // Clamp into [0, 1.0]
  always_comb begin
    if (h_lin < 0) begin
      H_OUT = '0;
    end else if (h_lin > acc_t'(H_ONE)) begin
      H_OUT = H_ONE;
    end else begin
      H_OUT = word_t'(h_lin);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Send FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state      <= DRAIN_IDLE;
      lane_idx   <= '0;
      drain_done <= 1'b0;
    end else begin
      drain_done <= 1'b0;

      case (state)
        DRAIN_IDLE: begin
          // All lanes step together, lane 0 speaks for them
          if (lane_done) begin
            lane_idx <= '0;
            state    <= DRAIN_SEND;
          end
        end

        DRAIN_SEND: begin
          // H_READY low holds index and word
          if (h_xfer) begin
            if (last_lane) begin
              lane_idx   <= '0;
              drain_done <= 1'b1;
              state      <= DRAIN_IDLE;
            end else begin
              lane_idx <= lane_idx + 1'b1;
            end
          end
        end

        default: begin
          state <= DRAIN_IDLE;
        end
      endcase
    end
  end

  // Row snapshot on completion
  always_ff @(posedge CLK) begin
    if (state == DRAIN_IDLE && lane_done) begin
      acc_row_q <= acc_row;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/ntm_controller.sv ====
////////////////////////////////////////////////////////////////////////////
// NTM controller layer
// h = logistic(W*z + b) for four neurons: feeder broadcasts operand
// beats to the lanes, the drain turns the sums into h words
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module ntm_controller
  import ntm_pkg::*;
(
  input  wire       CLK,
  input  wire       RST,
  // Job start
  input  wire       START,
  output logic      READY,
  input  len_t      LENGTH_IN,
  input  word_row_t B_IN,
  // Operand stream, x then r
  input  wire       X_VALID,
  output logic      X_READY,
  input  word_t     X_ELEM,
  input  word_row_t X_WEIGHTS,
  // Result stream
  output logic      H_VALID,
  input  wire       H_READY,
  output word_t     H_OUT,
  output logic      H_LAST
);

  // Feeder to lanes
  logic      lane_load;
  word_row_t bias_row;
  logic      lane_step;
  logic      lane_last;
  word_t     step_elem;
  word_row_t step_weights;

  // Lanes to drain
  acc_row_t               acc_row;
  logic [NUM_LANES-1:0]   lane_done;
  logic                   drain_done;

  ////////////////////////////////////////////////////////////////////////////
  // Operand feeder
  ////////////////////////////////////////////////////////////////////////////

  ntm_operand_feeder u_feeder (
    .CLK          (CLK),
    .RST          (RST),
    .START        (START),
    .READY        (READY),
    .LENGTH_IN    (LENGTH_IN),
    .B_IN         (B_IN),
    .X_VALID      (X_VALID),
    .X_READY      (X_READY),
    .X_ELEM       (X_ELEM),
    .X_WEIGHTS    (X_WEIGHTS),
    .drain_done   (drain_done),
    .lane_load    (lane_load),
    .bias_row     (bias_row),
    .lane_step    (lane_step),
    .lane_last    (lane_last),
    .step_elem    (step_elem),
    .step_weights (step_weights)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Neuron lanes
  ////////////////////////////////////////////////////////////////////////////

  // Lane n takes word n of the rows, writes slot n of the sums
  for (genvar n = 0; n < NUM_LANES; n++) begin : gen_lane
    ntm_neuron_lane u_lane (
      .CLK       (CLK),
      .RST       (RST),
      .lane_load (lane_load),
      .bias      (bias_row[n*WORD_W +: WORD_W]),
      .lane_step (lane_step),
      .lane_last (lane_last),
      .step_elem (step_elem),
      .weight    (step_weights[n*WORD_W +: WORD_W]),
      .acc       (acc_row[n*ACC_W +: ACC_W]),
      .lane_done (lane_done[n])
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // Logistic drain
  ////////////////////////////////////////////////////////////////////////////

  // Lanes run in lockstep so lane 0 done is enough
  ntm_logistic_drain u_drain (
    .CLK        (CLK),
    .RST        (RST),
    .lane_done  (lane_done[0]),
    .acc_row    (acc_row),
    .H_VALID    (H_VALID),
    .H_READY    (H_READY),
    .H_OUT      (H_OUT),
    .H_LAST     (H_LAST),
    .drain_done (drain_done)
  );

endmodule

`default_nettype wire

// ==== tests/ntm_controller_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// NTM controller testbench
// Replays jobs from the vector file through the controller, with
// optional operand gaps, result stalls and a START sent while busy,
// and compares every h word and H_LAST against the file
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module ntm_controller_tb
  import ntm_pkg::*;
();

  localparam int MAX_BEATS = 32;

  // DUT ports
  logic      CLK;
  logic      RST;
  logic      START;
  logic      READY;
  len_t      LENGTH_IN;
  word_row_t B_IN;
  logic      X_VALID;
  logic      X_READY;
  word_t     X_ELEM;
  word_row_t X_WEIGHTS;
  logic      H_VALID;
  logic      H_READY;
  word_t     H_OUT;
  logic      H_LAST;

  // Current job as read from the file
  len_t      job_len;
  int        job_stall;
  word_row_t job_bias;
  word_t     beat_elem [MAX_BEATS];
  word_row_t beat_weights [MAX_BEATS];
  word_t     exp_h [NUM_LANES];
  int        num_beats;

  // Run bookkeeping
  int errors;
  int jobs_run;
  int jobs_total;
  int cycles;
  int cycle_limit;
  int fd;
  int seed;
  int unsigned seed_ret;

  ntm_controller u_ntm_controller (
    .CLK       (CLK),
    .RST       (RST),
    .START     (START),
    .READY     (READY),
    .LENGTH_IN (LENGTH_IN),
    .B_IN      (B_IN),
    .X_VALID   (X_VALID),
    .X_READY   (X_READY),
    .X_ELEM    (X_ELEM),
    .X_WEIGHTS (X_WEIGHTS),
    .H_VALID   (H_VALID),
    .H_READY   (H_READY),
    .H_OUT     (H_OUT),
    .H_LAST    (H_LAST)
  );

  // 40 unit period
  always #20 CLK = ~CLK;

  // Run limit, raised once the job count is known
  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d clock cycles", cycles);
      $display("Test FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic flag_error(input string msg);
    errors++;
    $display("ERROR at time %0t: %s", $time, msg);
  endtask

  // Called on a falling edge, returns on one
  task automatic wait_ready();
    while (READY !== 1'b1) begin
      @(negedge CLK);
    end
  endtask

  task automatic check_idle_after_reset();
    repeat (3) begin
      if (READY !== 1'b1) flag_error("READY not high after reset");
      if (X_READY !== 1'b0) flag_error("X_READY not low after reset");
      if (H_VALID !== 1'b0) flag_error("H_VALID not low after reset");
      @(negedge CLK);
    end
  endtask

  // One job: start, operand beats, optional busy START, four h words
  task automatic run_job();
    int    i;
    int    k;
    logic  held;
    word_t held_out;
    logic  held_last;

    wait_ready();
    START     = 1'b1;
    LENGTH_IN = job_len;
    B_IN      = job_bias;
    @(negedge CLK);
    START = 1'b0;
    if (READY !== 1'b0) flag_error("READY still high after START");

    // Gaps put junk on the data lines
    i = 0;
    while (i < num_beats) begin
      if ((job_stall & 1) != 0 && $urandom % 3 == 0) begin
        X_VALID   = 1'b0;
        X_ELEM    = word_t'($urandom);
        X_WEIGHTS = {$urandom, $urandom};
      end else begin
        X_VALID   = 1'b1;
        X_ELEM    = beat_elem[i];
        X_WEIGHTS = beat_weights[i];
        if (X_READY === 1'b1) i++;
      end
      if (READY !== 1'b0) flag_error("READY high while operands stream");
      @(negedge CLK);
    end
    X_VALID = 1'b0;

    // START while busy must be dropped
    if ((job_stall & 4) != 0) begin
      if (READY !== 1'b0) flag_error("READY high before results were sent");
      START     = 1'b1;
      LENGTH_IN = len_t'(3);
      B_IN      = {$urandom, $urandom};
      @(negedge CLK);
      START = 1'b0;
    end

    k    = 0;
    held = 1'b0;
    while (k < NUM_LANES) begin
      if ((job_stall & 2) != 0) begin
        H_READY = ($urandom % 2) == 1;
      end else begin
        H_READY = 1'b1;
      end
      // Word stalled last cycle must not move
      if (held && (H_VALID !== 1'b1 || H_OUT !== held_out || H_LAST !== held_last))
        flag_error($sformatf("h word changed during stall, lane %0d", k));
      held = 1'b0;
      if (H_VALID === 1'b1) begin
        if (H_READY) begin
          if (H_OUT !== exp_h[k])
            flag_error($sformatf("lane %0d h is %h, expected %h", k, H_OUT, exp_h[k]));
          if (H_LAST !== (k == NUM_LANES - 1))
            flag_error($sformatf("lane %0d H_LAST is %b", k, H_LAST));
          k++;
        end else begin
          held      = 1'b1;
          held_out  = H_OUT;
          held_last = H_LAST;
        end
      end
      if (X_READY !== 1'b0) flag_error("X_READY high while results drain");
      if (READY !== 1'b0) flag_error("READY high before the last h word");
      @(negedge CLK);
    end
    if (H_VALID !== 1'b0) flag_error("H_VALID still high after the last word");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Vector file parser
  ////////////////////////////////////////////////////////////////////////////

  task automatic read_vectors();
    logic [8*8-1:0]   tag;
    logic [8*128-1:0] rest;
    int               code;
    int               len_i;
    int               lane;
    word_t            v;
    logic             more;

    more = 1'b1;
    while (more) begin
      code = $fscanf(fd, "%s", tag);
      if (code != 1) begin
        more = 1'b0;
      end else if (tag == "#") begin
        code = $fgets(rest, fd);
      end else if (tag == "N") begin
        code        = $fscanf(fd, "%d", jobs_total);
        cycle_limit = 200 * jobs_total + 100;
      end else if (tag == "J") begin
        code    = $fscanf(fd, "%d %d", len_i, job_stall);
        job_len = len_t'(len_i);
        for (lane = 0; lane < NUM_LANES; lane++) begin
          code = $fscanf(fd, "%h", v);
          job_bias[lane*WORD_W +: WORD_W] = v;
        end
        num_beats = 0;
      end else if (tag == "B" && num_beats < MAX_BEATS) begin
        code = $fscanf(fd, "%h", v);
        beat_elem[num_beats] = v;
        for (lane = 0; lane < NUM_LANES; lane++) begin
          code = $fscanf(fd, "%h", v);
          beat_weights[num_beats][lane*WORD_W +: WORD_W] = v;
        end
        num_beats++;
      end else if (tag == "E") begin
        for (lane = 0; lane < NUM_LANES; lane++) begin
          code = $fscanf(fd, "%h", v);
          exp_h[lane] = v;
        end
        run_job();
        jobs_run++;
      end else begin
        $display("Vector file has a bad entry or too many beats, reading stopped");
        errors++;
        more = 1'b0;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    seed        = 32'hc471588e;
    seed_ret    = $urandom(seed);
    errors      = 0;
    jobs_run    = 0;
    jobs_total  = 0;
    cycles      = 0;
    cycle_limit = 100;
    num_beats   = 0;
    CLK         = 1'b0;
    RST         = 1'b1;
    START       = 1'b0;
    LENGTH_IN   = '0;
    B_IN        = '0;
    X_VALID     = 1'b0;
    X_ELEM      = '0;
    X_WEIGHTS   = '0;
    H_READY     = 1'b0;

    fd = $fopen("tests/ntm_controller_vectors.txt", "r");
    if (fd == 0) begin
      $display("Cannot open tests/ntm_controller_vectors.txt");
      errors++;
    end

    repeat (3) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
    check_idle_after_reset();

    if (fd != 0) begin
      read_vectors();
      $fclose(fd);
      wait_ready();
    end

    if (jobs_run != jobs_total) begin
      $display("Only %0d of %0d jobs in the vector file were run", jobs_run, jobs_total);
      errors++;
    end
    $display("Jobs run: %0d, errors: %0d", jobs_run, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/ntm_controller_vectors.txt ====
# N jobs; J length stall bias0..3; B elem weight0..3 per beat; E h0..3 expected
# Values hex Q8.8; stall bit0 X_VALID gaps, bit1 H_READY stalls, bit2 START while busy
N 6
# Plain two-beat job
J 2 0 0000 0100 ff00 0080
B 0100 0100 0080 0200 ff80
B 0080 0100 ff00 0040 0100
E 00e0 00c0 00c8 00a0
# Operand gaps
J 3 1 0040 ffc0 0000 0020
B 0180 0100 0040 ff00 0000
B ff80 0080 0100 0100 0200
B 0040 fc00 0400 0200 0100
E 00a0 00a8 0020 0058
# Result stalls, rounding toward minus infinity
J 1 2 0000 0000 0000 0000
B 0001 0001 ffff 0100 ff00
E 0080 007f 0080 007f
# All stalls and a START while busy
J 2 7 0080 0000 ff80 0100
B 0100 0080 0100 0040 ff00
B ff00 0040 ff80 0100 0080
E 00b0 00e0 0030 0060
# Large sums clamp to 1.0 and 0
J 2 0 7f00 8100 0000 0000
B 0400 0400 0400 1000 f000
B 0200 0000 0000 0000 0000
E 0100 0000 0100 0000
# Accumulator saturation
J 4 1 0000 0000 0000 0040
B 8000 8000 8000 7fff 0000
B 8000 8000 8000 7fff 0000
B 8000 7fff ffff 7fff 0000
B 8000 7fff 0000 8000 fffe
E 00bf 0100 0000 00d0

// ==== compile.f ====
hdl/ntm_pkg.sv
hdl/ntm_operand_feeder.sv
hdl/ntm_neuron_lane.sv
hdl/ntm_logistic_drain.sv
hdl/ntm_controller.sv
tests/ntm_controller_tb.sv

// ==== Bender.yml ====
package:
  name: ntm_controller

sources:
  - hdl/ntm_pkg.sv
  - hdl/ntm_operand_feeder.sv
  - hdl/ntm_neuron_lane.sv
  - hdl/ntm_logistic_drain.sv
  - hdl/ntm_controller.sv
  - target: test
    files:
      - tests/ntm_controller_tb.sv
